/* src/link_proto_pkg.sv */
// Link wire format for the byte-stream test responder
// Header byte holds a 2-bit command and a 6-bit payload length
`default_nettype none

package link_proto_pkg;

    // ==========================================================
    // Basic link types
    // ==========================================================
    typedef logic [7:0] byte_t;
    typedef logic [5:0] len_t;

    // Frame commands, top two bits of the header
    typedef enum logic [1:0] {
        CMD_TEST_START   = 2'd0,
        CMD_TEST_DATA    = 2'd1,
        CMD_TEST_STOP    = 2'd2,
        CMD_TEST_STOPPED = 2'd3
    } cmd_t;

    // ==========================================================
    // Header layout
    // ==========================================================
    localparam int HDR_CMD_MSB = 7;
    localparam int HDR_CMD_LSB = 6;
    localparam int HDR_LEN_MSB = 5;
    localparam int HDR_LEN_LSB = 0;

    // Command field of a header byte
    function automatic cmd_t hdr_cmd(byte_t hdr);
        return cmd_t'(hdr[HDR_CMD_MSB:HDR_CMD_LSB]);
    endfunction

    // Payload length field of a header byte
    function automatic len_t hdr_len(byte_t hdr);
        return hdr[HDR_LEN_MSB:HDR_LEN_LSB];
    endfunction

    // Build a header from command and length
    function automatic byte_t make_hdr(cmd_t cmd, len_t len);
        return {cmd, len};
    endfunction

endpackage

`default_nettype wire

/* src/test_proto_pkg.sv */
// Test engine protocol: test numbers, error codes, reply frame layout
`default_nettype none

package test_proto_pkg;

    // ==========================================================
    // Test numbers, first START payload byte
    // ==========================================================
    typedef logic [7:0] test_num_t;

    localparam test_num_t TEST_RECEIVE      = 8'd1;
    // No longer supported, answered as a bad test number
    localparam test_num_t TEST_SEND         = 8'd2;
    localparam test_num_t TEST_RECEIVE_SEND = 8'd3;

    // ==========================================================
    // Error codes carried by TEST_STOPPED
    // ==========================================================
    typedef logic [7:0] err_t;

    localparam err_t ERR_NONE      = 8'd0;
    localparam err_t ERR_START_LEN = 8'd1;
    localparam err_t ERR_STOP_LEN  = 8'd2;
    localparam err_t ERR_BAD_CMD   = 8'd3;
    localparam err_t ERR_BAD_TEST  = 8'd4;
    localparam err_t ERR_BAD_DATA  = 8'd5;

    // ==========================================================
    // Reply frame layout
    // ==========================================================
    // Largest reply, header plus three payload bytes
    localparam logic [2:0] REPLY_MAX = 3'd4;
    typedef logic [2:0] reply_len_t;

    // Byte positions inside a reply frame
    localparam int REPLY_HDR_IDX = 0;
    // Error code, or the echoed byte of a loop-back reply
    localparam int REPLY_P0_IDX  = 1;
    // Received byte or rejected test number
    localparam int REPLY_P1_IDX  = 2;
    // Expected byte
    localparam int REPLY_P2_IDX  = 3;

endpackage

`default_nettype wire

/* src/frame_parser.sv */
// Frame parser for the input FIFO
// Pops bytes and splits each frame into a header strobe and payload strobes
`timescale 1ns/1ps
`default_nettype none

module frame_parser
    import link_proto_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  hold_i,
    // Show-ahead input FIFO
    input  logic  in_fifo_empty_i,
    input  byte_t in_fifo_data_i,
    output logic  in_fifo_rd_o,
    // Header strobe
    output logic  hdr_stb_o,
    output cmd_t  hdr_cmd_o,
    output len_t  hdr_len_o,
    // Payload strobe
    output logic  pay_stb_o,
    output cmd_t  pay_cmd_o,
    output byte_t pay_byte_o
);

    // Popping enabled one cycle after reset releases
    logic run_q;
    // Low while waiting for a header, high inside a payload
    logic in_payload_q;
    // Payload bytes still to come
    len_t remain_q;
    // Command of the frame being parsed
    cmd_t cur_cmd_q;

    // ==========================================================
    // FIFO pop and strobes
    // ==========================================================
    // Byte is taken in the same cycle as the pop
    assign in_fifo_rd_o = run_q && !in_fifo_empty_i && !hold_i;

    assign hdr_stb_o = in_fifo_rd_o && !in_payload_q;
    assign hdr_cmd_o = hdr_cmd(in_fifo_data_i);
    assign hdr_len_o = hdr_len(in_fifo_data_i);

    assign pay_stb_o  = in_fifo_rd_o && in_payload_q;
    assign pay_cmd_o  = cur_cmd_q;
    assign pay_byte_o = in_fifo_data_i;

    // ==========================================================
    // Frame state
    // ==========================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            run_q        <= 1'b0;
            in_payload_q <= 1'b0;
            remain_q     <= '0;
            cur_cmd_q    <= CMD_TEST_START;
        end else begin
            run_q <= 1'b1;
            if (hdr_stb_o) begin
                cur_cmd_q <= hdr_cmd_o;
                // Empty frames stay in header state
                if (hdr_len_o != '0) begin
                    in_payload_q <= 1'b1;
                    remain_q     <= hdr_len_o;
                end
            end else if (pay_stb_o) begin
                remain_q <= remain_q - len_t'(1);
                // Last payload byte, next byte is a header
                if (remain_q == len_t'(1)) begin
                    in_payload_q <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/test_engine.sv */
// Test engine for the link responder
// Runs the receive and loop-back tests on parsed bytes
// Builds TEST_DATA echoes and TEST_STOPPED status replies
`timescale 1ns/1ps
`default_nettype none

module test_engine
    import link_proto_pkg::*;
    import test_proto_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    // Parsed header
    input  logic       hdr_stb_i,
    input  cmd_t       hdr_cmd_i,
    input  len_t       hdr_len_i,
    // Parsed payload byte
    input  logic       pay_stb_i,
    input  cmd_t       pay_cmd_i,
    input  byte_t      pay_byte_i,
    // Reply to the buffer
    output logic       reply_load_o,
    output reply_len_t reply_len_o,
    output byte_t      reply_bytes_o [REPLY_MAX],
    // Test status
    output logic       test_ok_o,
    output logic       test_fail_o
);

    // Engine state
    logic      running_q;
    test_num_t test_num_q;
    byte_t     expected_q;
    logic      ok_q;
    logic      fail_q;

    // Decoded events of this cycle
    logic       start_ok;
    logic       num_ok;
    logic       data_ok;
    logic       echo;
    logic       stop_req;
    err_t       stop_err;
    // Payload length of the STOPPED reply
    reply_len_t stop_plen;
    byte_t      stop_arg0;
    byte_t      stop_arg1;

    // ==========================================================
    // Event decode
    // ==========================================================
    always_comb begin
        start_ok  = 1'b0;
        num_ok    = 1'b0;
        data_ok   = 1'b0;
        echo      = 1'b0;
        stop_req  = 1'b0;
        stop_err  = ERR_NONE;
        stop_plen = 3'd1;
        stop_arg0 = '0;
        stop_arg1 = '0;

        // START headers count even when stopped
        if (hdr_stb_i) begin
            case (hdr_cmd_i)
                CMD_TEST_START: begin
                    if (hdr_len_i == len_t'(1)) begin
                        start_ok = 1'b1;
                    end else begin
                        stop_req = 1'b1;
                        stop_err = ERR_START_LEN;
                    end
                end
                CMD_TEST_STOP: begin
                    if (running_q) begin
                        stop_req = 1'b1;
                        stop_err = (hdr_len_i == '0) ? ERR_NONE : ERR_STOP_LEN;
                    end
                end
                CMD_TEST_STOPPED: begin
                    // Only the responder sends this one
                    if (running_q) begin
                        stop_req = 1'b1;
                        stop_err = ERR_BAD_CMD;
                    end
                end
                default: begin
                    // DATA frames are handled per payload byte
                end
            endcase
        end

        // Payload bytes count only while running
        if (pay_stb_i && running_q) begin
            case (pay_cmd_i)
                CMD_TEST_START: begin
                    case (pay_byte_i)
                        TEST_RECEIVE, TEST_RECEIVE_SEND: begin
                            num_ok = 1'b1;
                        end
                        default: begin
                            // Unknown numbers and the unsupported send test
                            stop_req  = 1'b1;
                            stop_err  = ERR_BAD_TEST;
                            stop_plen = 3'd2;
                            stop_arg0 = pay_byte_i;
                        end
                    endcase
                end
                CMD_TEST_DATA: begin
                    if (pay_byte_i == expected_q) begin
                        data_ok = 1'b1;
                        echo    = (test_num_q == TEST_RECEIVE_SEND);
                    end else begin
                        stop_req  = 1'b1;
                        stop_err  = ERR_BAD_DATA;
                        stop_plen = 3'd3;
                        stop_arg0 = pay_byte_i;
                        stop_arg1 = expected_q;
                    end
                end
                default: begin
                    // STOP and STOPPED payloads come after the stop
                end
            endcase
        end
    end

    // ==========================================================
    // Reply build in the cycle of the strobe
    // ==========================================================
    always_comb begin
        reply_load_o = stop_req || echo;
        // Frame length counts the header byte
        reply_len_o  = stop_req ? stop_plen + 3'd1 : 3'd2;
        for (int i = 0; i < int'(REPLY_MAX); i++) begin
            reply_bytes_o[i] = '0;
        end
        if (stop_req) begin
            reply_bytes_o[REPLY_HDR_IDX] = make_hdr(CMD_TEST_STOPPED, len_t'(stop_plen));
            reply_bytes_o[REPLY_P0_IDX]  = stop_err;
            reply_bytes_o[REPLY_P1_IDX]  = stop_arg0;
            reply_bytes_o[REPLY_P2_IDX]  = stop_arg1;
        end else begin
            // Loop-back echo of one good byte
            reply_bytes_o[REPLY_HDR_IDX] = make_hdr(CMD_TEST_DATA, len_t'(1));
            reply_bytes_o[REPLY_P0_IDX]  = pay_byte_i;
        end
    end

    // ==========================================================
    // State update
    // ==========================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            running_q  <= 1'b0;
            test_num_q <= TEST_RECEIVE;
            expected_q <= '0;
            ok_q       <= 1'b0;
            fail_q     <= 1'b0;
        end else begin
            if (start_ok) begin
                running_q  <= 1'b1;
                expected_q <= '0;
                ok_q       <= 1'b0;
                fail_q     <= 1'b0;
            end
            if (num_ok) begin
                test_num_q <= pay_byte_i;
            end
            // Counter wraps at 8 bits
            if (data_ok) begin
                expected_q <= expected_q + 8'd1;
            end
            // A stop writes both flags so only one is ever high
            if (stop_req) begin
                running_q <= 1'b0;
                ok_q      <= (stop_err == ERR_NONE);
                fail_q    <= (stop_err != ERR_NONE);
            end
        end
    end

    assign test_ok_o   = ok_q;
    assign test_fail_o = fail_q;

endmodule

`default_nettype wire

/* src/reply_buffer.sv */
// Reply buffer for the output FIFO
// Holds one reply frame and drains it one byte per cycle of room
`timescale 1ns/1ps
`default_nettype none

module reply_buffer
    import link_proto_pkg::*;
    import test_proto_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    // Reply load from the engine
    input  logic       load_i,
    input  reply_len_t len_i,
    input  byte_t      bytes_i [REPLY_MAX],
    output logic       busy_o,
    // Output FIFO
    input  logic       out_fifo_full_i,
    input  logic       out_fifo_afull_i,
    output logic       out_fifo_wr_o,
    output byte_t      out_fifo_data_o
);

    localparam int IDX_W = $clog2(int'(REPLY_MAX));

    // Frame storage with the header first
    byte_t            mem_q [REPLY_MAX];
    // Next byte to write
    logic [IDX_W-1:0] rd_idx_q;
    // Bytes still to write
    reply_len_t       left_q;
    logic             busy_q;

    // ==========================================================
    // Output FIFO write
    // ==========================================================
    // Both output FIFO flags must be clear for a write
    assign out_fifo_wr_o   = busy_q && !out_fifo_full_i && !out_fifo_afull_i;
    assign out_fifo_data_o = mem_q[rd_idx_q];
    assign busy_o          = busy_q;

    // Frame bytes
    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int i = 0; i < int'(REPLY_MAX); i++) begin
                mem_q[i] <= bytes_i[i];
            end
        end
    end

    // ==========================================================
    // Drain control
    // ==========================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_q   <= 1'b0;
            rd_idx_q <= '0;
            left_q   <= '0;
        end else if (load_i) begin
            busy_q   <= 1'b1;
            rd_idx_q <= '0;
            left_q   <= len_i;
        end else if (out_fifo_wr_o) begin
            rd_idx_q <= rd_idx_q + 1'b1;
            left_q   <= left_q - 3'd1;
            // Parser may pop again once the last byte is out
            if (left_q == 3'd1) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/link_test_top.sv */
// Link test responder top level
// Frame parser feeds the test engine, replies go out through the buffer
`timescale 1ns/1ps
`default_nettype none

module link_test_top
    import link_proto_pkg::*;
    import test_proto_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    // Input FIFO
    input  logic  in_fifo_empty_i,
    input  byte_t in_fifo_data_i,
    output logic  in_fifo_rd_o,
    // Output FIFO
    input  logic  out_fifo_full_i,
    input  logic  out_fifo_afull_i,
    output logic  out_fifo_wr_o,
    output byte_t out_fifo_data_o,
    // Test status
    output logic  test_ok_o,
    output logic  test_fail_o
);

    // Parser strobes
    logic       hdr_stb;
    cmd_t       hdr_cmd;
    len_t       hdr_len;
    logic       pay_stb;
    cmd_t       pay_cmd;
    byte_t      pay_byte;

    // Engine reply
    logic       reply_load;
    reply_len_t reply_len;
    byte_t      reply_bytes [REPLY_MAX];
    // One reply in flight, parser waits on it
    logic       reply_busy;

    frame_parser parser_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .hold_i          (reply_busy),
        .in_fifo_empty_i (in_fifo_empty_i),
        .in_fifo_data_i  (in_fifo_data_i),
        .in_fifo_rd_o    (in_fifo_rd_o),
        .hdr_stb_o       (hdr_stb),
        .hdr_cmd_o       (hdr_cmd),
        .hdr_len_o       (hdr_len),
        .pay_stb_o       (pay_stb),
        .pay_cmd_o       (pay_cmd),
        .pay_byte_o      (pay_byte)
    );

    test_engine engine_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .hdr_stb_i     (hdr_stb),
        .hdr_cmd_i     (hdr_cmd),
        .hdr_len_i     (hdr_len),
        .pay_stb_i     (pay_stb),
        .pay_cmd_i     (pay_cmd),
        .pay_byte_i    (pay_byte),
        .reply_load_o  (reply_load),
        .reply_len_o   (reply_len),
        .reply_bytes_o (reply_bytes),
        .test_ok_o     (test_ok_o),
        .test_fail_o   (test_fail_o)
    );

    reply_buffer buffer_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .load_i           (reply_load),
        .len_i            (reply_len),
        .bytes_i          (reply_bytes),
        .busy_o           (reply_busy),
        .out_fifo_full_i  (out_fifo_full_i),
        .out_fifo_afull_i (out_fifo_afull_i),
        .out_fifo_wr_o    (out_fifo_wr_o),
        .out_fifo_data_o  (out_fifo_data_o)
    );

endmodule

`default_nettype wire

/* sim/link_test_assert.sv */
// Bound checker for the link test responder
// FIFO handshake rules and exclusive status outputs
`timescale 1ns/1ps
`default_nettype none

module link_test_assert (
    input logic clk,
    input logic reset_i,
    // Input FIFO side
    input logic in_empty_i,
    input logic in_rd_i,
    // Output FIFO side
    input logic out_full_i,
    input logic out_afull_i,
    input logic out_wr_i,
    // Status
    input logic ok_i,
    input logic fail_i
);

    // Pop only with a byte at the head
    no_read_when_empty: assert property (
        @(posedge clk) disable iff (reset_i) in_rd_i |-> !in_empty_i
    ) else $error("input FIFO read while empty");

    // Both flags must be clear for a write
    no_write_when_full: assert property (
        @(posedge clk) disable iff (reset_i) out_wr_i |-> !(out_full_i || out_afull_i)
    ) else $error("output FIFO written while full or almost full");

    // Pass and fail never shown together
    status_exclusive: assert property (
        @(posedge clk) !(ok_i && fail_i)
    ) else $error("test_ok_o and test_fail_o both high");

endmodule

bind link_test_top link_test_assert assert_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_empty_i  (in_fifo_empty_i),
    .in_rd_i     (in_fifo_rd_o),
    .out_full_i  (out_fifo_full_i),
    .out_afull_i (out_fifo_afull_i),
    .out_wr_i    (out_fifo_wr_o),
    .ok_i        (test_ok_o),
    .fail_i      (test_fail_o)
);

`default_nettype wire

/* sim/tb_link_test.sv */
// Testbench for the link test responder
// Show-ahead input FIFO model, output capture, reference model of the
// engine rules and a byte-by-byte compare of the reply stream
`timescale 1ns/1ps
`default_nettype none

module tb_link_test
    import link_proto_pkg::*;
    import test_proto_pkg::*;
();

    typedef byte_t byte_q_t [$];

    localparam int          NUM_TESTS    = 5;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'h7bca_4e24;

    // DUT ports
    logic  clk;
    logic  reset_i;
    logic  in_fifo_empty_i;
    byte_t in_fifo_data_i;
    logic  in_fifo_rd_o;
    logic  out_fifo_full_i;
    logic  out_fifo_afull_i;
    logic  out_fifo_wr_o;
    byte_t out_fifo_data_o;
    logic  test_ok_o;
    logic  test_fail_o;

    // All test streams back to back with t_first marking each start
    byte_q_t all_stim;
    int      t_first [NUM_TESTS+1];
    string   t_name [NUM_TESTS];
    logic    t_bp [NUM_TESTS];

    // Live FIFO model and expected replies
    byte_q_t in_q;
    byte_q_t exp_q;
    int      cap_idx = 0;
    logic    bp_en = 1'b0;
    int      errors = 0;
    int      passed = 0;
    int      cycles = 0;
    int      cycle_limit = 0;

    link_test_top dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .in_fifo_empty_i  (in_fifo_empty_i),
        .in_fifo_data_i   (in_fifo_data_i),
        .in_fifo_rd_o     (in_fifo_rd_o),
        .out_fifo_full_i  (out_fifo_full_i),
        .out_fifo_afull_i (out_fifo_afull_i),
        .out_fifo_wr_o    (out_fifo_wr_o),
        .out_fifo_data_o  (out_fifo_data_o),
        .test_ok_o        (test_ok_o),
        .test_fail_o      (test_fail_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==========================================================
    // FIFO models
    // ==========================================================
    // Head byte and output flags change on the falling edge
    initial begin
        void'($urandom(SEED));
        in_fifo_empty_i  = 1'b1;
        in_fifo_data_i   = 8'h00;
        out_fifo_full_i  = 1'b0;
        out_fifo_afull_i = 1'b0;
        forever begin
            @(negedge clk);
            in_fifo_empty_i = (in_q.size() == 0);
            in_fifo_data_i  = (in_q.size() != 0) ? in_q[0] : 8'h00;
            // Random back-pressure blocks about two cycles in five
            out_fifo_full_i  = bp_en && (($urandom % 5) == 0);
            out_fifo_afull_i = bp_en && (($urandom % 4) == 0);
        end
    end

    // Pop, capture and compare on the rising edge
    always @(posedge clk) begin
        cycles++;
        if (!reset_i) begin
            if (in_fifo_rd_o && in_q.size() != 0) begin
                void'(in_q.pop_front());
            end
            assert (!(in_fifo_rd_o && in_fifo_empty_i)) else begin
                $display("ERROR at %0t: input FIFO read while empty", $time);
                errors++;
            end
            assert (!(out_fifo_wr_o && (out_fifo_full_i || out_fifo_afull_i))) else begin
                $display("ERROR at %0t: output FIFO written while full", $time);
                errors++;
            end
            if (out_fifo_wr_o) begin
                assert (cap_idx < exp_q.size()) else begin
                    $display("ERROR at %0t: reply byte %02h written after the expected stream",
                             $time, out_fifo_data_o);
                    errors++;
                end
                if (cap_idx < exp_q.size()) begin
                    assert (out_fifo_data_o == exp_q[cap_idx]) else begin
                        $display("[FAIL] t=%0t out_fifo_data_o[%0d] got %02h expected %02h",
                                 $time, cap_idx, out_fifo_data_o, exp_q[cap_idx]);
                        errors++;
                    end
                end
                cap_idx++;
            end
        end
    end

    // ==========================================================
    // Reference model of the engine rules
    // ==========================================================
    function automatic void ref_model(input byte_q_t stim, output byte_q_t exp_bytes,
                                      output logic exp_ok, output logic exp_fail);
        logic       running;
        byte_t      test_num;
        byte_t      expected;
        logic       in_pay;
        int         remain;
        logic [1:0] cur_cmd;
        logic [1:0] cmd;
        logic [5:0] len;
        byte_t      b;
        logic       stop;
        byte_t      err;
        int         plen;
        byte_t      arg0;
        byte_t      arg1;
        running   = 1'b0;
        test_num  = TEST_RECEIVE;
        expected  = 8'h00;
        in_pay    = 1'b0;
        remain    = 0;
        cur_cmd   = CMD_TEST_START;
        exp_ok    = 1'b0;
        exp_fail  = 1'b0;
        exp_bytes = {};
        foreach (stim[i]) begin
            b    = stim[i];
            stop = 1'b0;
            err  = ERR_NONE;
            plen = 1;
            arg0 = 8'h00;
            arg1 = 8'h00;
            if (!in_pay) begin
                // Header has the command on top and the length below
                cmd     = b[7:6];
                len     = b[5:0];
                cur_cmd = cmd;
                if (len != 6'd0) begin
                    in_pay = 1'b1;
                    remain = int'(len);
                end
                case (cmd)
                    CMD_TEST_START: begin
                        if (len == 6'd1) begin
                            running  = 1'b1;
                            expected = 8'h00;
                            exp_ok   = 1'b0;
                            exp_fail = 1'b0;
                        end else begin
                            stop = 1'b1;
                            err  = ERR_START_LEN;
                        end
                    end
                    CMD_TEST_STOP: begin
                        if (running) begin
                            stop = 1'b1;
                            err  = (len == 6'd0) ? ERR_NONE : ERR_STOP_LEN;
                        end
                    end
                    CMD_TEST_STOPPED: begin
                        if (running) begin
                            stop = 1'b1;
                            err  = ERR_BAD_CMD;
                        end
                    end
                    default: begin
                    end
                endcase
            end else begin
                remain--;
                if (remain == 0) begin
                    in_pay = 1'b0;
                end
                if (running && cur_cmd == CMD_TEST_START) begin
                    if (b == TEST_RECEIVE || b == TEST_RECEIVE_SEND) begin
                        test_num = b;
                    end else begin
                        stop = 1'b1;
                        err  = ERR_BAD_TEST;
                        plen = 2;
                        arg0 = b;
                    end
                end else if (running && cur_cmd == CMD_TEST_DATA) begin
                    if (b == expected) begin
                        expected++;
                        // Loop-back echo in its own DATA frame
                        if (test_num == TEST_RECEIVE_SEND) begin
                            exp_bytes.push_back({CMD_TEST_DATA, 6'd1});
                            exp_bytes.push_back(b);
                        end
                    end else begin
                        stop = 1'b1;
                        err  = ERR_BAD_DATA;
                        plen = 3;
                        arg0 = b;
                        arg1 = expected;
                    end
                end
            end
            if (stop) begin
                running  = 1'b0;
                exp_ok   = (err == ERR_NONE);
                exp_fail = (err != ERR_NONE);
                exp_bytes.push_back({CMD_TEST_STOPPED, 6'(plen)});
                exp_bytes.push_back(err);
                if (plen >= 2) begin
                    exp_bytes.push_back(arg0);
                end
                if (plen >= 3) begin
                    exp_bytes.push_back(arg1);
                end
            end
        end
    endfunction

    // ==========================================================
    // Stimulus builders
    // ==========================================================
    task automatic add_hdr(input logic [1:0] cmd, input logic [5:0] len);
        all_stim.push_back({cmd, len});
    endtask

    task automatic add_start(input byte_t num);
        add_hdr(CMD_TEST_START, 6'd1);
        all_stim.push_back(num);
    endtask

    // DATA frame of an incrementing run
    task automatic add_data(input byte_t first, input int count);
        add_hdr(CMD_TEST_DATA, 6'(count));
        for (int i = 0; i < count; i++) begin
            all_stim.push_back(first + 8'(i));
        end
    endtask

    task automatic mark_test(input int idx, input string name, input logic bp);
        t_first[idx] = all_stim.size();
        t_name[idx]  = name;
        t_bp[idx]    = bp;
    endtask

    task automatic build_stimulus();
        mark_test(0, "receive", 1'b0);
        add_start(TEST_RECEIVE);
        add_data(8'd0, 5);
        add_data(8'd5, 5);
        add_hdr(CMD_TEST_STOP, 6'd0);
        mark_test(1, "loop-back with back-pressure", 1'b1);
        add_start(TEST_RECEIVE_SEND);
        add_data(8'd0, 20);
        add_hdr(CMD_TEST_STOP, 6'd0);
        // Byte 5 replaced by 9
        mark_test(2, "wrong data", 1'b0);
        add_start(TEST_RECEIVE);
        add_data(8'd0, 5);
        add_hdr(CMD_TEST_DATA, 6'd5);
        all_stim.push_back(8'd9);
        for (int v = 6; v < 10; v++) begin
            all_stim.push_back(8'(v));
        end
        add_hdr(CMD_TEST_STOP, 6'd0);
        mark_test(3, "start errors", 1'b0);
        add_start(TEST_SEND);
        add_hdr(CMD_TEST_START, 6'd2);
        all_stim.push_back(TEST_RECEIVE);
        all_stim.push_back(8'd7);
        // DATA before START, then bad STOP length, then STOPPED as input
        mark_test(4, "other errors", 1'b0);
        add_data(8'd0, 3);
        add_start(TEST_RECEIVE);
        add_hdr(CMD_TEST_STOP, 6'd1);
        all_stim.push_back(8'h00);
        add_start(TEST_RECEIVE);
        add_hdr(CMD_TEST_STOPPED, 6'd0);
        t_first[NUM_TESTS] = all_stim.size();
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    task automatic run_one_test(input int idx);
        byte_q_t stim;
        logic    exp_ok;
        logic    exp_fail;
        int      err_before;
        int      idle;
        for (int i = t_first[idx]; i < t_first[idx+1]; i++) begin
            stim.push_back(all_stim[i]);
        end
        @(negedge clk);
        reset_i = 1'b1;
        ref_model(stim, exp_q, exp_ok, exp_fail);
        in_q       = stim;
        cap_idx    = 0;
        bp_en      = t_bp[idx];
        err_before = errors;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        // Input drained and buffer idle for a few cycles
        idle = 0;
        while (idle < 4) begin
            @(negedge clk);
            if (in_q.size() == 0 && !dut_i.reply_busy) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        bp_en = 1'b0;
        assert (cap_idx == exp_q.size()) else begin
            $display("[FAIL] t=%0t reply byte count got %0d expected %0d",
                     $time, cap_idx, exp_q.size());
            errors++;
        end
        assert (test_ok_o == exp_ok) else begin
            $display("[FAIL] t=%0t test_ok_o got %0b expected %0b", $time, test_ok_o, exp_ok);
            errors++;
        end
        assert (test_fail_o == exp_fail) else begin
            $display("[FAIL] t=%0t test_fail_o got %0b expected %0b",
                     $time, test_fail_o, exp_fail);
            errors++;
        end
        if (errors == err_before) begin
            passed++;
            $display("test %0d (%s): pass, %0d reply bytes", idx + 1, t_name[idx], cap_idx);
        end else begin
            $display("test %0d (%s): fail, %0d errors", idx + 1, t_name[idx],
                     errors - err_before);
        end
    endtask

    initial begin
        reset_i = 1'b1;
        build_stimulus();
        cycle_limit = 40 * all_stim.size() + 2000;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_one_test(t);
        end
        $display("Summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog on the total cycle count
    initial begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("Timeout: no result after %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/link_proto_pkg.sv
src/test_proto_pkg.sv
src/frame_parser.sv
src/test_engine.sv
src/reply_buffer.sv
src/link_test_top.sv
sim/link_test_assert.sv
sim/tb_link_test.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the link test responder testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_link_test -o tb_link_test > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_link_test > "$SIM_LOG" 2>&1 \
    || echo "Simulator exited with an error status"

cat "$SIM_LOG"

grep -qx "TB PASSED" "$SIM_LOG" \
    && { echo "Simulation result: pass"; exit 0; } \
    || { echo "Simulation result: fail"; exit 1; }
